//--- files.f
hw/isa_pkg.sv
hw/ex_ctrl_pkg.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/operand_fwd.sv
hw/id_ex_reg.sv
hw/id_stage.sv
verif/id_stage_asserts.sv
verif/id_stage_tb.sv

//--- Makefile
obj_dir/Vid_stage_tb: files.f $(wildcard hw/*.sv verif/*.sv)
	verilator --binary --assert --timing -f files.f --top-module id_stage_tb

run: obj_dir/Vid_stage_tb
	./obj_dir/Vid_stage_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- verif/id_stage_tb.sv
module id_stage_tb;

    // forwarding inputs of one row
    typedef struct packed {
        logic               ld;
        logic               ex_wreg;
        isa_pkg::reg_addr_t ex_wd;
        isa_pkg::word_t     ex_wdata;
        logic               mem_wreg;
        isa_pkg::reg_addr_t mem_wd;
        isa_pkg::word_t     mem_wdata;
    } fwd_t;

    // expected outputs of the stage register
    typedef struct packed {
        ex_ctrl_pkg::alu_op_t  aluop;
        ex_ctrl_pkg::res_sel_t alusel;
        logic                  wreg;
        isa_pkg::reg_addr_t    wd;
        isa_pkg::word_t        reg1;
        isa_pkg::word_t        reg2;
        isa_pkg::word_t        imm;
    } ex_t;

    localparam int N_ROWS        = 19;
    localparam int WATCHDOG_TIME = (8 + N_ROWS + 10) * 10;

    localparam isa_pkg::word_t RF1  = 32'h1111_0001;    // register file data
    localparam isa_pkg::word_t RF2  = 32'h2222_0002;
    localparam isa_pkg::word_t RF1B = 32'h5555_1001;    // second data set
    localparam isa_pkg::word_t RF2B = 32'h6666_2002;
    localparam isa_pkg::word_t EXD  = 32'hE0E0_0E0E;
    localparam isa_pkg::word_t MEMD = 32'h3030_0303;
    localparam isa_pkg::word_t UIMM = 32'hABCD_E000;
    localparam isa_pkg::word_t W0   = 32'h0;

    localparam fwd_t NO_FWD = fwd_t'{1'b0, 1'b0, 5'd0, W0, 1'b0, 5'd0, W0};
    localparam ex_t  BUBBLE = ex_t'{ex_ctrl_pkg::ALU_NOP, ex_ctrl_pkg::RES_NOP,
                                    1'b0, 5'd0, W0, W0, W0};

    logic                  clk_i = 1'b0;
    logic                  rst_n_i;
    isa_pkg::inst_t        inst_i;
    isa_pkg::word_t        reg1_data_i;
    isa_pkg::word_t        reg2_data_i;
    logic                  reg1_read_o;
    logic                  reg2_read_o;
    isa_pkg::reg_addr_t    reg1_addr_o;
    isa_pkg::reg_addr_t    reg2_addr_o;
    logic                  ex_ld_i;
    logic                  ex_wreg_i;
    isa_pkg::reg_addr_t    ex_wd_i;
    isa_pkg::word_t        ex_wdata_i;
    logic                  mem_wreg_i;
    isa_pkg::reg_addr_t    mem_wd_i;
    isa_pkg::word_t        mem_wdata_i;
    logic                  stall_o;
    ex_ctrl_pkg::alu_op_t  ex_aluop_o;
    ex_ctrl_pkg::res_sel_t ex_alusel_o;
    logic                  ex_wreg_o;
    isa_pkg::reg_addr_t    ex_wd_o;
    isa_pkg::word_t        ex_reg1_o;
    isa_pkg::word_t        ex_reg2_o;
    isa_pkg::word_t        ex_imm_o;

    string          row_name [N_ROWS];
    isa_pkg::inst_t row_inst [N_ROWS];
    isa_pkg::word_t row_rf1  [N_ROWS];
    isa_pkg::word_t row_rf2  [N_ROWS];
    fwd_t           row_fwd  [N_ROWS];
    logic [2:0]     row_comb [N_ROWS];    // {reg1_read, reg2_read, stall}
    ex_t            row_ex   [N_ROWS];
    int             n_rows = 0;

    id_stage i_dut (.*);

    always #5 clk_i = ~clk_i;

    task automatic fail_now();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic add_row(input string nm, input isa_pkg::inst_t ins,
                           input isa_pkg::word_t rf1, input isa_pkg::word_t rf2,
                           input fwd_t f, input logic [2:0] comb, input ex_t e);
        if (n_rows < N_ROWS) begin
            row_name[n_rows] = nm;
            row_inst[n_rows] = ins;
            row_rf1[n_rows]  = rf1;
            row_rf2[n_rows]  = rf2;
            row_fwd[n_rows]  = f;
            row_comb[n_rows] = comb;
            row_ex[n_rows]   = e;
        end
        n_rows++;
    endtask

    task automatic drive_row(input int i);
        inst_i      = row_inst[i];
        reg1_data_i = row_rf1[i];
        reg2_data_i = row_rf2[i];
        ex_ld_i     = row_fwd[i].ld;
        ex_wreg_i   = row_fwd[i].ex_wreg;
        ex_wd_i     = row_fwd[i].ex_wd;
        ex_wdata_i  = row_fwd[i].ex_wdata;
        mem_wreg_i  = row_fwd[i].mem_wreg;
        mem_wd_i    = row_fwd[i].mem_wd;
        mem_wdata_i = row_fwd[i].mem_wdata;
    endtask

    task automatic check_comb(input int i);
        logic [2:0] act_v;
        logic [9:0] exp_addr;
        act_v    = {reg1_read_o, reg2_read_o, stall_o};
        exp_addr = {row_inst[i][19:15], row_inst[i][24:20]};    // rs1, rs2 fields
        assert (act_v === row_comb[i]) else begin
            $display("mismatch %s read/stall: expected %b, actual %b",
                     row_name[i], row_comb[i], act_v);
            fail_now();
        end
        assert ({reg1_addr_o, reg2_addr_o} === exp_addr) else begin
            $display("mismatch %s read addresses: expected %h, actual %h",
                     row_name[i], exp_addr, {reg1_addr_o, reg2_addr_o});
            fail_now();
        end
    endtask

    task automatic check_ex(input string nm, input ex_t exp_v);
        ex_t act_v;
        act_v = '{ex_aluop_o, ex_alusel_o, ex_wreg_o, ex_wd_o, ex_reg1_o, ex_reg2_o, ex_imm_o};
        assert (act_v === exp_v) else begin
            $display("mismatch %s ex outputs: expected %p, actual %p", nm, exp_v, act_v);
            fail_now();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and expected values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_table();
        add_row("add", 32'h002081B3, RF1, RF2, NO_FWD, 3'b110,
                ex_t'{ex_ctrl_pkg::ALU_ADD, ex_ctrl_pkg::RES_ARITH, 1'b1, 5'd3, RF1, RF2, W0});
        add_row("sub", 32'h402081B3, RF1B, RF2B, NO_FWD, 3'b110,
                ex_t'{ex_ctrl_pkg::ALU_SUB, ex_ctrl_pkg::RES_ARITH, 1'b1, 5'd3, RF1B, RF2B, W0});
        add_row("sltu", 32'h0020B1B3, RF1, RF2, NO_FWD, 3'b110,
                ex_t'{ex_ctrl_pkg::ALU_SLTU, ex_ctrl_pkg::RES_ARITH, 1'b1, 5'd3, RF1, RF2, W0});
        add_row("xor", 32'h0020C1B3, RF1B, RF2B, NO_FWD, 3'b110,
                ex_t'{ex_ctrl_pkg::ALU_XOR, ex_ctrl_pkg::RES_LOGIC, 1'b1, 5'd3, RF1B, RF2B, W0});
        add_row("sll", 32'h002091B3, RF1, RF2, NO_FWD, 3'b110,
                ex_t'{ex_ctrl_pkg::ALU_SLL, ex_ctrl_pkg::RES_SHIFT, 1'b1, 5'd3, RF1, RF2, W0});
        add_row("sra", 32'h4020D1B3, RF1B, RF2B, NO_FWD, 3'b110,
                ex_t'{ex_ctrl_pkg::ALU_SRA, ex_ctrl_pkg::RES_SHIFT, 1'b1, 5'd3, RF1B, RF2B, W0});
        add_row("addi_neg", 32'hFFB08193, RF1, RF2, NO_FWD, 3'b100,
                ex_t'{ex_ctrl_pkg::ALU_ADD, ex_ctrl_pkg::RES_ARITH, 1'b1, 5'd3, RF1,
                      32'hFFFF_FFFB, 32'hFFFF_FFFB});
        add_row("andi", 32'h7F00F193, RF1B, RF2B, NO_FWD, 3'b100,
                ex_t'{ex_ctrl_pkg::ALU_AND, ex_ctrl_pkg::RES_LOGIC, 1'b1, 5'd3, RF1B,
                      32'h7F0, 32'h7F0});
        add_row("srai", 32'h4070D193, RF1, RF2, NO_FWD, 3'b100,      // shamt 7 only
                ex_t'{ex_ctrl_pkg::ALU_SRA, ex_ctrl_pkg::RES_SHIFT, 1'b1, 5'd3, RF1,
                      32'd7, 32'd7});
        add_row("lui", 32'hABCDE1B7, RF1B, RF2B, NO_FWD, 3'b000,
                ex_t'{ex_ctrl_pkg::ALU_OR, ex_ctrl_pkg::RES_LOGIC, 1'b1, 5'd3, UIMM, UIMM, UIMM});
        add_row("lh", 32'hFF009183, RF1, RF2, NO_FWD, 3'b100,
                ex_t'{ex_ctrl_pkg::ALU_LH, ex_ctrl_pkg::RES_LD_ST, 1'b1, 5'd3, RF1,
                      32'hFFFF_FFF0, 32'hFFFF_FFF0});
        add_row("sw", 32'hFE20AA23, RF1B, RF2B, NO_FWD, 3'b110,    // rd field holds imm[4:0]
                ex_t'{ex_ctrl_pkg::ALU_SW, ex_ctrl_pkg::RES_LD_ST, 1'b0, 5'd20, RF1B, RF2B,
                      32'hFFFF_FFF4});
        add_row("fwd_ex_over_mem", 32'h002081B3, RF1, RF2,
                fwd_t'{1'b0, 1'b1, 5'd1, EXD, 1'b1, 5'd1, MEMD}, 3'b110,
                ex_t'{ex_ctrl_pkg::ALU_ADD, ex_ctrl_pkg::RES_ARITH, 1'b1, 5'd3, EXD, RF2, W0});
        add_row("fwd_mem_and_ex", 32'h002081B3, RF1B, RF2B,
                fwd_t'{1'b0, 1'b1, 5'd2, EXD, 1'b1, 5'd1, MEMD}, 3'b110,
                ex_t'{ex_ctrl_pkg::ALU_ADD, ex_ctrl_pkg::RES_ARITH, 1'b1, 5'd3, MEMD, EXD, W0});
        add_row("fwd_skip_x0", 32'h002001B3, RF1, RF2,
                fwd_t'{1'b1, 1'b1, 5'd0, EXD, 1'b1, 5'd0, MEMD}, 3'b110,
                ex_t'{ex_ctrl_pkg::ALU_ADD, ex_ctrl_pkg::RES_ARITH, 1'b1, 5'd3, RF1, RF2, W0});
        add_row("load_use_rs2", 32'h002081B3, RF1B, RF2B,
                fwd_t'{1'b1, 1'b1, 5'd2, EXD, 1'b0, 5'd0, W0}, 3'b111, BUBBLE);
        add_row("load_use_rs1", 32'hFF009183, RF1, RF2,
                fwd_t'{1'b1, 1'b1, 5'd1, EXD, 1'b0, 5'd0, W0}, 3'b101, BUBBLE);
        add_row("load_unread_src", 32'hABCDE1B7, RF1B, RF2B,     // lui rs1 field is 27
                fwd_t'{1'b1, 1'b1, 5'd27, EXD, 1'b0, 5'd0, W0}, 3'b000,
                ex_t'{ex_ctrl_pkg::ALU_OR, ex_ctrl_pkg::RES_LOGIC, 1'b1, 5'd3, UIMM, UIMM, UIMM});
        add_row("beq_nop", 32'h00208063, RF1, RF2, NO_FWD, 3'b000, BUBBLE);
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the test sequence did not complete in the expected time");
        fail_now();
    end

    initial begin
        rst_n_i     = 1'b0;
        inst_i      = '0;
        reg1_data_i = RF1;
        reg2_data_i = RF2;
        drive_row_idle: begin
            ex_ld_i     = 1'b0;
            ex_wreg_i   = 1'b0;
            ex_wd_i     = '0;
            ex_wdata_i  = '0;
            mem_wreg_i  = 1'b0;
            mem_wd_i    = '0;
            mem_wdata_i = '0;
        end
        build_table();
        assert (n_rows == N_ROWS) else begin
            $display("stimulus table holds %0d rows instead of %0d", n_rows, N_ROWS);
            fail_now();
        end

        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        check_ex("after_reset", BUBBLE);

        for (int i = 0; i < N_ROWS; i++) begin
            drive_row(i);
            @(negedge clk_i);
            check_comb(i);
            @(posedge clk_i);
            #1;
            check_ex(row_name[i], row_ex[i]);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- verif/id_stage_asserts.sv
module id_stage_asserts (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input isa_pkg::inst_t       inst_i,
    input isa_pkg::reg_addr_t   dut_reg1_addr_i,
    input logic                 dut_stall_i,
    input logic                 dut_ex_wreg_i,
    input ex_ctrl_pkg::alu_op_t dut_ex_aluop_i
);

    a_stall_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dut_stall_i |=> !dut_ex_wreg_i)
        else $error("stall was not followed by a bubble");

    a_rs1_addr: assert property (@(posedge clk_i)
        dut_reg1_addr_i == inst_i[19:15])
        else $error("reg1 address differs from the rs1 field");

    a_reset_idle: assert property (@(posedge clk_i)
        !rst_n_i |=> (!dut_ex_wreg_i && dut_ex_aluop_i == ex_ctrl_pkg::ALU_NOP))
        else $error("execute controls active after a reset edge");

endmodule

bind id_stage id_stage_asserts u_asserts (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .inst_i          (inst_i),
    .dut_reg1_addr_i (reg1_addr_o),
    .dut_stall_i     (stall_o),
    .dut_ex_wreg_i   (ex_wreg_o),
    .dut_ex_aluop_i  (ex_aluop_o)
);

//--- hw/id_stage.sv
module id_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  isa_pkg::inst_t        inst_i,
    // register file
    input  isa_pkg::word_t        reg1_data_i,
    input  isa_pkg::word_t        reg2_data_i,
    output logic                  reg1_read_o,
    output logic                  reg2_read_o,
    output isa_pkg::reg_addr_t    reg1_addr_o,
    output isa_pkg::reg_addr_t    reg2_addr_o,
    // forwarding from execute and memory
    input  logic                  ex_ld_i,
    input  logic                  ex_wreg_i,
    input  isa_pkg::reg_addr_t    ex_wd_i,
    input  isa_pkg::word_t        ex_wdata_i,
    input  logic                  mem_wreg_i,
    input  isa_pkg::reg_addr_t    mem_wd_i,
    input  isa_pkg::word_t        mem_wdata_i,
    output logic                  stall_o,
    // to execute
    output ex_ctrl_pkg::alu_op_t  ex_aluop_o,
    output ex_ctrl_pkg::res_sel_t ex_alusel_o,
    output logic                  ex_wreg_o,
    output isa_pkg::reg_addr_t    ex_wd_o,
    output isa_pkg::word_t        ex_reg1_o,
    output isa_pkg::word_t        ex_reg2_o,
    output isa_pkg::word_t        ex_imm_o
);

    isa_pkg::reg_addr_t    rd;
    ex_ctrl_pkg::alu_op_t  aluop;
    ex_ctrl_pkg::res_sel_t alusel;
    logic                  wreg;
    isa_pkg::imm_fmt_t     imm_fmt;
    isa_pkg::word_t        imm;
    isa_pkg::word_t        reg1;
    isa_pkg::word_t        reg2;
    logic                  stall1;
    logic                  stall2;

    assign rd          = inst_i[11:7];
    assign reg1_addr_o = inst_i[19:15];    // rs1, driven even when unread
    assign reg2_addr_o = inst_i[24:20];    // rs2
    assign stall_o     = stall1 | stall2;

    inst_decoder u_dec (
        .inst_i      (inst_i),
        .aluop_o     (aluop),
        .alusel_o    (alusel),
        .wreg_o      (wreg),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .imm_fmt_o   (imm_fmt)
    );

    imm_gen u_imm (
        .inst_i    (inst_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand select, one per source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    operand_fwd u_fwd1 (
        .read_i (reg1_read_o), .addr_i (reg1_addr_o), .rf_data_i (reg1_data_i),
        .imm_i (imm), .ex_ld_i (ex_ld_i), .ex_wreg_i (ex_wreg_i), .ex_wd_i (ex_wd_i),
        .ex_wdata_i (ex_wdata_i), .mem_wreg_i (mem_wreg_i), .mem_wd_i (mem_wd_i),
        .mem_wdata_i (mem_wdata_i), .operand_o (reg1), .stall_o (stall1)
    );

    operand_fwd u_fwd2 (
        .read_i (reg2_read_o), .addr_i (reg2_addr_o), .rf_data_i (reg2_data_i),
        .imm_i (imm), .ex_ld_i (ex_ld_i), .ex_wreg_i (ex_wreg_i), .ex_wd_i (ex_wd_i),
        .ex_wdata_i (ex_wdata_i), .mem_wreg_i (mem_wreg_i), .mem_wd_i (mem_wd_i),
        .mem_wdata_i (mem_wdata_i), .operand_o (reg2), .stall_o (stall2)
    );

    id_ex_reg u_id_ex (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_o),
        .aluop_i     (aluop),
        .alusel_i    (alusel),
        .wreg_i      (wreg),
        .wd_i        (rd),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .imm_i       (imm),
        .ex_aluop_o  (ex_aluop_o),
        .ex_alusel_o (ex_alusel_o),
        .ex_wreg_o   (ex_wreg_o),
        .ex_wd_o     (ex_wd_o),
        .ex_reg1_o   (ex_reg1_o),
        .ex_reg2_o   (ex_reg2_o),
        .ex_imm_o    (ex_imm_o)
    );

endmodule

//--- hw/id_ex_reg.sv
module id_ex_reg (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  ex_ctrl_pkg::alu_op_t  aluop_i,
    input  ex_ctrl_pkg::res_sel_t alusel_i,
    input  logic                  wreg_i,
    input  isa_pkg::reg_addr_t    wd_i,
    input  isa_pkg::word_t        reg1_i,
    input  isa_pkg::word_t        reg2_i,
    input  isa_pkg::word_t        imm_i,
    output ex_ctrl_pkg::alu_op_t  ex_aluop_o,
    output ex_ctrl_pkg::res_sel_t ex_alusel_o,
    output logic                  ex_wreg_o,
    output isa_pkg::reg_addr_t    ex_wd_o,
    output isa_pkg::word_t        ex_reg1_o,
    output isa_pkg::word_t        ex_reg2_o,
    output isa_pkg::word_t        ex_imm_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage register, bubble on reset or stall
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || stall_i) begin
            ex_aluop_o  <= ex_ctrl_pkg::BUBBLE_ALUOP;
            ex_alusel_o <= ex_ctrl_pkg::BUBBLE_ALUSEL;
            ex_wreg_o   <= ex_ctrl_pkg::BUBBLE_WREG;
            ex_wd_o     <= '0;
            ex_reg1_o   <= '0;
            ex_reg2_o   <= '0;
            ex_imm_o    <= '0;
        end else begin
            ex_aluop_o  <= aluop_i;
            ex_alusel_o <= alusel_i;
            ex_wreg_o   <= wreg_i;
            ex_wd_o     <= wd_i;
            ex_reg1_o   <= reg1_i;
            ex_reg2_o   <= reg2_i;
            ex_imm_o    <= imm_i;
        end
    end

endmodule

//--- hw/operand_fwd.sv
module operand_fwd (
    input  logic              read_i,
    input  isa_pkg::reg_addr_t addr_i,
    input  isa_pkg::word_t    rf_data_i,
    input  isa_pkg::word_t    imm_i,
    input  logic              ex_ld_i,
    input  logic              ex_wreg_i,
    input  isa_pkg::reg_addr_t ex_wd_i,
    input  isa_pkg::word_t    ex_wdata_i,
    input  logic              mem_wreg_i,
    input  isa_pkg::reg_addr_t mem_wd_i,
    input  isa_pkg::word_t    mem_wdata_i,
    output isa_pkg::word_t    operand_o,
    output logic              stall_o
);

    logic addr_nz;
    logic ex_match;
    logic mem_match;

    assign addr_nz   = (addr_i != '0);    // x0 never forwards or stalls
    assign ex_match  = addr_nz && (ex_wd_i == addr_i);
    assign mem_match = addr_nz && (mem_wd_i == addr_i);

    always_comb begin
        stall_o = 1'b0;
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_ld_i && ex_match) begin
            operand_o = '0;    // load data not ready yet
            stall_o   = 1'b1;
        end else if (ex_wreg_i && ex_match) begin
            operand_o = ex_wdata_i;
        end else if (mem_wreg_i && mem_match) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

//--- hw/imm_gen.sv
module imm_gen (
    input  isa_pkg::inst_t    inst_i,
    input  isa_pkg::imm_fmt_t imm_fmt_i,
    output isa_pkg::word_t    imm_o
);

    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [19:0] u_imm;
    logic [4:0]  shamt;

    assign i_imm = inst_i[31:20];
    assign s_imm = {inst_i[31:25], inst_i[11:7]};
    assign u_imm = inst_i[31:12];
    assign shamt = inst_i[24:20];

    always_comb begin
        case (imm_fmt_i)
            isa_pkg::IMM_I: begin
                imm_o = {{20{i_imm[11]}}, i_imm};
            end
            isa_pkg::IMM_SHAMT: begin
                imm_o = {27'd0, shamt};    // no sign, func7 bits dropped
            end
            isa_pkg::IMM_S: begin
                imm_o = {{20{s_imm[11]}}, s_imm};
            end
            isa_pkg::IMM_U: begin
                imm_o = {u_imm, 12'd0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

//--- hw/inst_decoder.sv
module inst_decoder (
    input  isa_pkg::inst_t        inst_i,
    output ex_ctrl_pkg::alu_op_t  aluop_o,
    output ex_ctrl_pkg::res_sel_t alusel_o,
    output logic                  wreg_o,
    output logic                  reg1_read_o,
    output logic                  reg2_read_o,
    output isa_pkg::imm_fmt_t     imm_fmt_o
);

    isa_pkg::opcode_t opcode;
    logic [2:0]       func3;
    logic [6:0]       func7;

    assign opcode = isa_pkg::opcode_t'(inst_i[6:0]);
    assign func3  = inst_i[14:12];
    assign func7  = inst_i[31:25];

    always_comb begin
        aluop_o     = ex_ctrl_pkg::ALU_NOP;
        alusel_o    = ex_ctrl_pkg::RES_NOP;
        wreg_o      = 1'b0;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        imm_fmt_o   = isa_pkg::IMM_NONE;

        case (opcode)
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // register-register and register-immediate ALU ops
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            isa_pkg::OPC_OP, isa_pkg::OPC_OP_IMM: begin
                case (func3)
                    isa_pkg::F3_ADD_SUB: begin
                        alusel_o = ex_ctrl_pkg::RES_ARITH;
                        if (opcode == isa_pkg::OPC_OP_IMM) begin
                            aluop_o = ex_ctrl_pkg::ALU_ADD;     // addi has no sub form
                        end else begin
                            case (func7)
                                isa_pkg::F7_BASE: aluop_o = ex_ctrl_pkg::ALU_ADD;
                                isa_pkg::F7_ALT:  aluop_o = ex_ctrl_pkg::ALU_SUB;
                                default:          alusel_o = ex_ctrl_pkg::RES_NOP;
                            endcase
                        end
                    end
                    isa_pkg::F3_SLT: begin
                        aluop_o  = ex_ctrl_pkg::ALU_SLT;
                        alusel_o = ex_ctrl_pkg::RES_ARITH;
                    end
                    isa_pkg::F3_SLTU: begin
                        aluop_o  = ex_ctrl_pkg::ALU_SLTU;
                        alusel_o = ex_ctrl_pkg::RES_ARITH;
                    end
                    isa_pkg::F3_XOR: begin
                        aluop_o  = ex_ctrl_pkg::ALU_XOR;
                        alusel_o = ex_ctrl_pkg::RES_LOGIC;
                    end
                    isa_pkg::F3_OR: begin
                        aluop_o  = ex_ctrl_pkg::ALU_OR;
                        alusel_o = ex_ctrl_pkg::RES_LOGIC;
                    end
                    isa_pkg::F3_AND: begin
                        aluop_o  = ex_ctrl_pkg::ALU_AND;
                        alusel_o = ex_ctrl_pkg::RES_LOGIC;
                    end
                    isa_pkg::F3_SLL: begin
                        aluop_o  = ex_ctrl_pkg::ALU_SLL;
                        alusel_o = ex_ctrl_pkg::RES_SHIFT;
                    end
                    isa_pkg::F3_SRL_SRA: begin
                        alusel_o = ex_ctrl_pkg::RES_SHIFT;
                        case (func7)
                            isa_pkg::F7_BASE: aluop_o = ex_ctrl_pkg::ALU_SRL;
                            isa_pkg::F7_ALT:  aluop_o = ex_ctrl_pkg::ALU_SRA;
                            default:          alusel_o = ex_ctrl_pkg::RES_NOP;
                        endcase
                    end
                    default: ;
                endcase

                if (aluop_o != ex_ctrl_pkg::ALU_NOP) begin   // bad func7 stays a NOP
                    wreg_o      = 1'b1;
                    reg1_read_o = 1'b1;
                    if (opcode == isa_pkg::OPC_OP) begin
                        reg2_read_o = 1'b1;
                    end else if (alusel_o == ex_ctrl_pkg::RES_SHIFT) begin
                        imm_fmt_o = isa_pkg::IMM_SHAMT;
                    end else begin
                        imm_fmt_o = isa_pkg::IMM_I;
                    end
                end
            end

            isa_pkg::OPC_LUI: begin
                aluop_o   = ex_ctrl_pkg::ALU_OR;    // imm OR imm in execute
                alusel_o  = ex_ctrl_pkg::RES_LOGIC;
                wreg_o    = 1'b1;
                imm_fmt_o = isa_pkg::IMM_U;
            end

            isa_pkg::OPC_LOAD: begin
                case (func3)
                    isa_pkg::F3_LB:  aluop_o = ex_ctrl_pkg::ALU_LB;
                    isa_pkg::F3_LH:  aluop_o = ex_ctrl_pkg::ALU_LH;
                    isa_pkg::F3_LW:  aluop_o = ex_ctrl_pkg::ALU_LW;
                    isa_pkg::F3_LBU: aluop_o = ex_ctrl_pkg::ALU_LBU;
                    isa_pkg::F3_LHU: aluop_o = ex_ctrl_pkg::ALU_LHU;
                    default: ;
                endcase
                if (aluop_o != ex_ctrl_pkg::ALU_NOP) begin
                    alusel_o    = ex_ctrl_pkg::RES_LD_ST;
                    wreg_o      = 1'b1;
                    reg1_read_o = 1'b1;
                    imm_fmt_o   = isa_pkg::IMM_I;
                end
            end

            isa_pkg::OPC_STORE: begin
                case (func3)
                    isa_pkg::F3_SB: aluop_o = ex_ctrl_pkg::ALU_SB;
                    isa_pkg::F3_SH: aluop_o = ex_ctrl_pkg::ALU_SH;
                    isa_pkg::F3_SW: aluop_o = ex_ctrl_pkg::ALU_SW;
                    default: ;
                endcase
                if (aluop_o != ex_ctrl_pkg::ALU_NOP) begin
                    alusel_o    = ex_ctrl_pkg::RES_LD_ST;
                    reg1_read_o = 1'b1;    // base
                    reg2_read_o = 1'b1;    // store data
                    imm_fmt_o   = isa_pkg::IMM_S;
                end
            end

            default: ;    // branch, jal, jalr, auipc and unknown
        endcase
    end

endmodule

//--- hw/ex_ctrl_pkg.sv
package ex_ctrl_pkg;

    typedef enum logic [4:0] {
        ALU_NOP  = 5'd0,
        ALU_ADD  = 5'd1,
        ALU_SUB  = 5'd2,
        ALU_SLT  = 5'd3,
        ALU_SLTU = 5'd4,
        ALU_XOR  = 5'd5,
        ALU_OR   = 5'd6,
        ALU_AND  = 5'd7,
        ALU_SLL  = 5'd8,
        ALU_SRL  = 5'd9,
        ALU_SRA  = 5'd10,
        ALU_LB   = 5'd11,
        ALU_LH   = 5'd12,
        ALU_LW   = 5'd13,
        ALU_LBU  = 5'd14,
        ALU_LHU  = 5'd15,
        ALU_SB   = 5'd16,
        ALU_SH   = 5'd17,
        ALU_SW   = 5'd18
    } alu_op_t;

    typedef enum logic [2:0] {
        RES_NOP   = 3'd0,
        RES_ARITH = 3'd1,
        RES_LOGIC = 3'd2,
        RES_SHIFT = 3'd3,
        RES_LD_ST = 3'd4
    } res_sel_t;

    // bubble control, data fields of a bubble are all zero
    localparam alu_op_t  BUBBLE_ALUOP  = ALU_NOP;
    localparam res_sel_t BUBBLE_ALUSEL = RES_NOP;
    localparam logic     BUBBLE_WREG   = 1'b0;

endpackage

//--- hw/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;     // register values, operands, immediates
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes kept in this core
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    // OP / OP-IMM func3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub / sra / srai

    typedef enum logic [2:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,   // sext inst[31:20]
        IMM_SHAMT = 3'd2,   // zext inst[24:20]
        IMM_S     = 3'd3,   // sext {inst[31:25], inst[11:7]}
        IMM_U     = 3'd4    // inst[31:12] << 12
    } imm_fmt_t;

endpackage
